//--- bench/rotator_patterns.hex
// one word per line, each block is a header then len_1+1 weight words
// header bits [11:4] hold len_1, bits [3:0] hold reps_1, upper bits unused
032
a001
a002
a003
a004
010
b001
b002
f051
c001
c002
c003
c004
c005
c006
003
d001
021
e001
e002
e003

//--- tb.f
rtl/rotator_pkg.sv
rtl/rotator_write_ctrl.sv
rtl/rotator_bank_ram.sv
rtl/rotator_replay_ctrl.sv
rtl/rotator_out_skid.sv
rtl/weight_rotator.sv
bench/weight_rotator_asserts.sv
bench/tb_weight_rotator.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator and run from the project root
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -j 0 \
       --top-module tb_weight_rotator -f tb.f -o sim_tb \
  && ./obj_dir/sim_tb \
  || { echo "build or run returned an error"; exit 1; }

//--- bench/tb_weight_rotator.sv
// **********************************************************
// weight rotator testbench
// sends the blocks of the pattern file with random gaps,
// stalls the output at random and checks every replayed
// word, its pass flags and its last marker
// **********************************************************
`timescale 1ns/100ps
`default_nettype none

module tb_weight_rotator;
  import rotator_pkg::*;

  localparam int WORD_W     = 16;
  localparam int DEPTH      = 256;
  localparam int WAIT_LIMIT = 2000;

  typedef struct packed {
    logic [WORD_W-1:0] data;
    out_user_t         user;
    logic              last;
  } exp_word_t;

  logic              aclk;
  logic              aresetn;
  logic              i_s_valid;
  logic              o_s_ready;
  logic [WORD_W-1:0] i_s_data;
  logic              i_s_last;
  logic              o_m_valid;
  logic              i_m_ready = 1'b0;
  logic [WORD_W-1:0] o_m_data;
  out_user_t         o_m_user;
  logic              o_m_last;

  // bit 16 marks entries the file did not fill
  logic [16:0] pat_mem [256];
  exp_word_t   exp_q [$];
  logic [31:0] lfsr_q   = 32'h2a5d548b;
  logic [1:0]  rnd_bits = 2'b00;

  weight_rotator #(.WORD_W(WORD_W), .DEPTH(DEPTH)) weight_rotator_i (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .i_s_valid(i_s_valid),
    .o_s_ready(o_s_ready),
    .i_s_data (i_s_data),
    .i_s_last (i_s_last),
    .o_m_valid(o_m_valid),
    .i_m_ready(i_m_ready),
    .o_m_data (o_m_data),
    .o_m_user (o_m_user),
    .o_m_last (o_m_last)
  );

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic wait_for_reset_release();
    int waited;
    waited = 0;
    @(posedge aclk);
    while (!aresetn) begin
      waited++;
      if (waited > WAIT_LIMIT) report_failure("reset was never released");
      @(posedge aclk);
    end
  endtask

  // every block gives reps_1+1 passes over its len_1+1 words
  task automatic build_expected();
    int        k;
    int        len;
    int        reps;
    hdr_t      hdr;
    exp_word_t e;
    k = 0;
    while (k < 256 && !pat_mem[8'(k)][16]) begin
      hdr  = hdr_t'(pat_mem[8'(k)][11:0]);
      len  = int'(hdr.len_1) + 1;
      reps = int'(hdr.reps_1) + 1;
      for (int p = 0; p < reps; p++) begin
        for (int w = 0; w < len; w++) begin
          e.data               = pat_mem[8'(k + 1 + w)][WORD_W-1:0];
          e.user.is_first_word = (w == 0);
          e.user.is_last_pass  = (p == reps - 1);
          e.last               = (w == len - 1) && (p == reps - 1);
          exp_q.push_back(e);
        end
      end
      k = k + len + 1;
    end
    if (exp_q.size() == 0) report_failure("pattern file holds no blocks");
  endtask

  // one beat held until the rotator takes it
  task automatic send_beat(input logic [WORD_W-1:0] data, input logic last);
    int waited;
    if (rnd_bits[0]) begin
      i_s_valid <= 1'b0;
      @(posedge aclk);
    end
    i_s_valid <= 1'b1;
    i_s_data  <= data;
    i_s_last  <= last;
    waited = 0;
    @(negedge aclk);
    while (!o_s_ready) begin
      waited++;
      if (waited > WAIT_LIMIT) report_failure("input stream stalled, o_s_ready stayed low");
      @(negedge aclk);
    end
    @(posedge aclk);
  endtask

  initial begin : clock_gen
    aclk = 1'b0;
    forever #20 aclk = ~aclk;
  end

  initial begin : reset_gen
    aresetn = 1'b0;
    repeat (16) @(posedge aclk);
    aresetn <= 1'b1;
  end

  // two bits per cycle for input gaps and ready
  always @(posedge aclk) begin : lfsr_step
    logic [31:0] s1;
    logic [31:0] s2;
    s1 = lfsr_next(lfsr_q);
    s2 = lfsr_next(s1);
    lfsr_q   <= s2;
    rnd_bits <= {s2[0], s1[0]};
  end

  always @(posedge aclk) begin
    if (!aresetn) i_m_ready <= 1'b0;
    else i_m_ready <= rnd_bits[1];
  end

  initial begin : driver
    int   k;
    int   len;
    hdr_t hdr;
    i_s_valid = 1'b0;
    i_s_data  = '0;
    i_s_last  = 1'b0;
    wait_for_reset_release();
    k = 0;
    while (k < 256 && !pat_mem[8'(k)][16]) begin
      hdr = hdr_t'(pat_mem[8'(k)][11:0]);
      len = int'(hdr.len_1) + 1;
      send_beat(pat_mem[8'(k)][WORD_W-1:0], 1'b0);
      for (int w = 0; w < len; w++) begin
        send_beat(pat_mem[8'(k + 1 + w)][WORD_W-1:0], (w == len - 1));
      end
      k = k + len + 1;
    end
    i_s_valid <= 1'b0;
    i_s_last  <= 1'b0;
  end

  initial begin : monitor
    exp_word_t e;
    int        waited;
    foreach (pat_mem[i]) pat_mem[i] = {1'b1, 16'(i)};
    $readmemh("bench/rotator_patterns.hex", pat_mem);
    build_expected();
    wait_for_reset_release();
    while (exp_q.size() > 0) begin
      e = exp_q.pop_front();
      waited = 0;
      @(negedge aclk);
      while (!(o_m_valid && i_m_ready)) begin
        waited++;
        if (waited > WAIT_LIMIT) report_failure("expected output word never arrived");
        @(negedge aclk);
      end
      check_value("o_m_data", 32'(o_m_data), 32'(e.data));
      check_value("o_m_user", 32'(o_m_user), 32'(e.user));
      check_value("o_m_last", 32'(o_m_last), 32'(e.last));
    end
    // nothing beyond the expected stream
    repeat (20) begin
      @(negedge aclk);
      check_value("o_m_valid", 32'(o_m_valid), 32'd0);
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/weight_rotator_asserts.sv
// **********************************************************
// weight rotator assertions
// output stream stability, bank flag rules, input last
// marker against the header count, state after reset
// **********************************************************
`timescale 1ns/100ps
`default_nettype none

module weight_rotator_asserts #(
  parameter int WORD_W = 16
) (
  input logic                     aclk,
  input logic                     aresetn,
  input logic                     i_in_valid,
  input logic                     i_in_ready,
  input logic                     i_in_last,
  input logic                     i_out_valid,
  input logic                     i_out_ready,
  input logic [WORD_W-1:0]        i_out_data,
  input rotator_pkg::out_user_t   i_out_user,
  input logic                     i_out_last,
  input rotator_pkg::bank_flags_t i_full,
  input rotator_pkg::bank_flags_t i_free,
  input logic                     i_last_word
);

  // stalled output word stays put
  assert property (@(posedge aclk) disable iff (!aresetn)
    i_out_valid && !i_out_ready |=> i_out_valid && $stable(i_out_data)
      && $stable(i_out_user) && $stable(i_out_last))
    else $error("output stream changed while stalled");

  assert property (@(posedge aclk) disable iff (!aresetn) (i_full & i_free) == 2'b00)
    else $error("a bank is flagged full and free at once");

  // last marker must agree with the header word count
  assert property (@(posedge aclk) disable iff (!aresetn)
    i_in_valid && i_in_ready |-> (i_in_last == i_last_word))
    else $error("input last marker disagrees with the header word count");

  assert property (@(posedge aclk) !aresetn |=> !i_out_valid && !i_in_ready)
    else $error("stream valid or ready high after a reset cycle");

endmodule

bind weight_rotator weight_rotator_asserts #(.WORD_W(WORD_W)) asserts_i (
  .aclk       (aclk),
  .aresetn    (aresetn),
  .i_in_valid (i_s_valid),
  .i_in_ready (o_s_ready),
  .i_in_last  (i_s_last),
  .i_out_valid(o_m_valid),
  .i_out_ready(i_m_ready),
  .i_out_data (o_m_data),
  .i_out_user (o_m_user),
  .i_out_last (o_m_last),
  .i_full     (full),
  .i_free     (write_ctrl_i.free_q),
  .i_last_word(write_ctrl_i.last_word)
);

`default_nettype wire

//--- rtl/weight_rotator.sv
// **********************************************************
// double-buffered weight rotator
// a header plus weight words come in on one stream, are
// stored in one of two banks and replayed on the output
// stream as many passes as the header asks for
// **********************************************************
`timescale 1ns/100ps
`default_nettype none

module weight_rotator #(
  parameter int WORD_W = 16,
  parameter int DEPTH  = 256
) (
  input  logic                     aclk,
  input  logic                     aresetn,
  input  logic                     i_s_valid,
  output logic                     o_s_ready,
  input  logic [WORD_W-1:0]        i_s_data,
  input  logic                     i_s_last,
  output logic                     o_m_valid,
  input  logic                     i_m_ready,
  output logic [WORD_W-1:0]        o_m_data,
  output rotator_pkg::out_user_t   o_m_user,
  output logic                     o_m_last
);
  import rotator_pkg::*;

  localparam int AW = $clog2(DEPTH);

  // bank handshake
  bank_flags_t full;
  hdr_t        rd_hdr;
  logic        take_rd;
  logic        release_rd;
  logic        rd_bank;

  // memory ports
  logic              wr_en;
  logic              wr_bank;
  logic [AW-1:0]     wr_addr;
  logic [WORD_W-1:0] wr_data;
  logic              rd_en;
  logic [AW-1:0]     rd_addr;
  logic [WORD_W-1:0] rd_data;

  // sideband toward the output stage
  out_user_t rd_user;
  logic      rd_last;
  logic      space;

  rotator_write_ctrl #(.WORD_W(WORD_W), .DEPTH(DEPTH)) write_ctrl_i (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .i_s_valid   (i_s_valid),
    .o_s_ready   (o_s_ready),
    .i_s_data    (i_s_data),
    .i_s_last    (i_s_last),
    .i_take_rd   (take_rd),
    .i_release_rd(release_rd),
    .i_rd_bank   (rd_bank),
    .o_full      (full),
    .o_rd_hdr    (rd_hdr),
    .o_wr_en     (wr_en),
    .o_wr_bank   (wr_bank),
    .o_wr_addr   (wr_addr),
    .o_wr_data   (wr_data)
  );

  rotator_bank_ram #(.WORD_W(WORD_W), .DEPTH(DEPTH)) bank_ram_i (
    .aclk     (aclk),
    .i_wr_en  (wr_en),
    .i_wr_bank(wr_bank),
    .i_wr_addr(wr_addr),
    .i_wr_data(wr_data),
    .i_rd_en  (rd_en),
    .i_rd_bank(rd_bank),
    .i_rd_addr(rd_addr),
    .o_rd_data(rd_data)
  );

  rotator_replay_ctrl #(.DEPTH(DEPTH)) replay_ctrl_i (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .i_full      (full),
    .i_hdr       (rd_hdr),
    .i_space     (space),
    .o_rd_bank   (rd_bank),
    .o_take_rd   (take_rd),
    .o_release_rd(release_rd),
    .o_rd_en     (rd_en),
    .o_rd_addr   (rd_addr),
    .o_user      (rd_user),
    .o_last      (rd_last)
  );

  rotator_out_skid #(.WORD_W(WORD_W)) out_skid_i (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .i_valid  (rd_en),
    .i_data   (rd_data),
    .i_user   (rd_user),
    .i_last   (rd_last),
    .o_space  (space),
    .o_m_valid(o_m_valid),
    .i_m_ready(i_m_ready),
    .o_m_data (o_m_data),
    .o_m_user (o_m_user),
    .o_m_last (o_m_last)
  );

endmodule

`default_nettype wire

//--- rtl/rotator_out_skid.sv
// **********************************************************
// weight rotator output stage
// two-entry buffer behind the bank memory. tracks the read
// in flight and only grants a new read when the word it
// returns is sure to find a free entry
// **********************************************************
`timescale 1ns/100ps
`default_nettype none

module rotator_out_skid #(
  parameter int WORD_W = 16
) (
  input  logic                     aclk,
  input  logic                     aresetn,
  input  logic                     i_valid,
  input  logic [WORD_W-1:0]        i_data,
  input  rotator_pkg::out_user_t   i_user,
  input  logic                     i_last,
  output logic                     o_space,
  output logic                     o_m_valid,
  input  logic                     i_m_ready,
  output logic [WORD_W-1:0]        o_m_data,
  output rotator_pkg::out_user_t   o_m_user,
  output logic                     o_m_last
);
  import rotator_pkg::*;

  typedef struct packed {
    logic [WORD_W-1:0] data;
    out_user_t         user;
    logic              last;
  } entry_t;

  entry_t     buf_q [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;
  logic       inflight;
  logic       push;
  logic       pop;
  logic [1:0] level;

  // i_valid is the read request and its data lands one cycle later
  assign push = inflight;
  assign pop  = o_m_valid && i_m_ready;

  // occupancy once the pending read has landed
  assign level   = count + 2'(inflight) - 2'(pop);
  assign o_space = (level <= 2'd1);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      inflight <= 1'b0;
      count    <= '0;
      wr_ptr   <= 1'b0;
      rd_ptr   <= 1'b0;
    end else begin
      inflight <= i_valid;
      count    <= count + 2'(push) - 2'(pop);
      if (push) wr_ptr <= ~wr_ptr;
      if (pop) rd_ptr <= ~rd_ptr;
    end
  end

  always_ff @(posedge aclk) begin
    if (push) buf_q[wr_ptr] <= '{data: i_data, user: i_user, last: i_last};
  end

  assign o_m_valid = (count != 2'd0);
  assign o_m_data  = buf_q[rd_ptr].data;
  assign o_m_user  = buf_q[rd_ptr].user;
  assign o_m_last  = buf_q[rd_ptr].last;

endmodule

`default_nettype wire

//--- rtl/rotator_replay_ctrl.sv
// **********************************************************
// weight rotator replay controller
// claims the next full bank, reads it pass by pass while
// the output stage has room, tags each word with its pass
// flags and hands the bank back after the final pass
// **********************************************************
`timescale 1ns/100ps
`default_nettype none

module rotator_replay_ctrl #(
  parameter int DEPTH = 256
) (
  input  logic                       aclk,
  input  logic                       aresetn,
  input  rotator_pkg::bank_flags_t   i_full,
  input  rotator_pkg::hdr_t          i_hdr,
  input  logic                       i_space,
  output logic                       o_rd_bank,
  output logic                       o_take_rd,
  output logic                       o_release_rd,
  output logic                       o_rd_en,
  output logic [$clog2(DEPTH)-1:0]   o_rd_addr,
  output rotator_pkg::out_user_t     o_user,
  output logic                       o_last
);
  import rotator_pkg::*;

  localparam int AW = $clog2(DEPTH);

  typedef enum logic [1:0] {R_IDLE, R_REPLAY, R_RELEASE} rd_state_t;

  rd_state_t           state;
  logic                rd_bank_q;
  logic [LEN_BITS-1:0] word_cnt;
  logic [REP_BITS-1:0] pass_cnt;
  logic                end_of_pass;
  logic                end_of_block;
  out_user_t           cur_user;

  assign o_take_rd    = (state == R_IDLE) && i_full[rd_bank_q];
  assign o_release_rd = (state == R_RELEASE);
  assign o_rd_en      = (state == R_REPLAY) && i_space;
  assign o_rd_addr    = AW'(word_cnt);
  assign o_rd_bank    = rd_bank_q;

  // flags of the word being read this cycle
  assign end_of_pass            = (word_cnt == i_hdr.len_1);
  assign cur_user.is_first_word = (word_cnt == '0);
  assign cur_user.is_last_pass  = (pass_cnt == i_hdr.reps_1);
  assign end_of_block           = end_of_pass && cur_user.is_last_pass;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state     <= R_IDLE;
      rd_bank_q <= 1'b0;
      word_cnt  <= '0;
      pass_cnt  <= '0;
    end else begin
      case (state)
        R_IDLE: begin
          if (o_take_rd) begin
            state    <= R_REPLAY;
            word_cnt <= '0;
            pass_cnt <= '0;
          end
        end
        R_REPLAY: begin
          if (o_rd_en) begin
            if (end_of_pass) begin
              word_cnt <= '0;
              if (cur_user.is_last_pass) state <= R_RELEASE;
              else pass_cnt <= pass_cnt + 1'b1;
            end else begin
              word_cnt <= word_cnt + 1'b1;
            end
          end
        end
        // last read already issued so the bank goes back
        R_RELEASE: begin
          state     <= R_IDLE;
          rd_bank_q <= ~rd_bank_q;
        end
        default: state <= R_IDLE;
      endcase
    end
  end

  // delayed to line up with the memory read data
  always_ff @(posedge aclk) begin
    if (o_rd_en) begin
      o_user <= cur_user;
      o_last <= end_of_block;
    end
  end

endmodule

`default_nettype wire

//--- rtl/rotator_bank_ram.sv
// **********************************************************
// weight rotator bank memory
// two banks of DEPTH words, one write port and one read
// port shared by both, read data registered one cycle
// **********************************************************
`timescale 1ns/100ps
`default_nettype none

module rotator_bank_ram #(
  parameter int WORD_W = 16,
  parameter int DEPTH  = 256
) (
  input  logic                     aclk,
  input  logic                     i_wr_en,
  input  logic                     i_wr_bank,
  input  logic [$clog2(DEPTH)-1:0] i_wr_addr,
  input  logic [WORD_W-1:0]        i_wr_data,
  input  logic                     i_rd_en,
  input  logic                     i_rd_bank,
  input  logic [$clog2(DEPTH)-1:0] i_rd_addr,
  output logic [WORD_W-1:0]        o_rd_data
);

  logic [WORD_W-1:0] mem [2][DEPTH];

  always_ff @(posedge aclk) begin
    if (i_wr_en) mem[i_wr_bank][i_wr_addr] <= i_wr_data;
  end

  // holds the last word read while no read is issued
  always_ff @(posedge aclk) begin
    if (i_rd_en) o_rd_data <= mem[i_rd_bank][i_rd_addr];
  end

endmodule

`default_nettype wire

//--- rtl/rotator_write_ctrl.sv
// **********************************************************
// weight rotator write controller
// accepts the header beat of a block, fills the next free
// bank with its weight words and marks that bank full.
// owns the full/free flag registers of both banks
// **********************************************************
`timescale 1ns/100ps
`default_nettype none

module rotator_write_ctrl #(
  parameter int WORD_W = 16,
  parameter int DEPTH  = 256
) (
  input  logic                       aclk,
  input  logic                       aresetn,
  input  logic                       i_s_valid,
  output logic                       o_s_ready,
  input  logic [WORD_W-1:0]          i_s_data,
  input  logic                       i_s_last,
  input  logic                       i_take_rd,
  input  logic                       i_release_rd,
  input  logic                       i_rd_bank,
  output rotator_pkg::bank_flags_t   o_full,
  output rotator_pkg::hdr_t          o_rd_hdr,
  output logic                       o_wr_en,
  output logic                       o_wr_bank,
  output logic [$clog2(DEPTH)-1:0]   o_wr_addr,
  output logic [WORD_W-1:0]          o_wr_data
);
  import rotator_pkg::*;

  localparam int AW = $clog2(DEPTH);

  typedef enum logic [1:0] {W_IDLE, W_HEADER, W_WRITE} wr_state_t;

  wr_state_t           state;
  bank_flags_t         full_q;
  bank_flags_t         free_q;
  hdr_t                hdr_q [2];
  logic                wr_bank_q;
  logic [LEN_BITS-1:0] wr_cnt;
  logic                s_hs;
  logic                take_wr;
  logic                last_word;

  // block length comes from the count and i_s_last is only a marker
  assign o_s_ready = (state == W_HEADER) || (state == W_WRITE);
  assign s_hs      = i_s_valid && o_s_ready;
  assign take_wr   = s_hs && (state == W_HEADER);
  assign last_word = s_hs && (state == W_WRITE) && (wr_cnt == hdr_q[wr_bank_q].len_1);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state     <= W_IDLE;
      wr_bank_q <= 1'b0;
      wr_cnt    <= '0;
    end else begin
      case (state)
        // wait until the reader has given this bank back
        W_IDLE: if (free_q[wr_bank_q]) state <= W_HEADER;
        W_HEADER: begin
          if (s_hs) begin
            state  <= W_WRITE;
            wr_cnt <= '0;
          end
        end
        W_WRITE: begin
          if (last_word) begin
            state     <= W_IDLE;
            wr_bank_q <= ~wr_bank_q;
          end else if (s_hs) begin
            wr_cnt <= wr_cnt + 1'b1;
          end
        end
        default: state <= W_IDLE;
      endcase
    end
  end

  // header of the block being written into this bank
  always_ff @(posedge aclk) begin
    if (take_wr) hdr_q[wr_bank_q] <= hdr_t'(i_s_data[$bits(hdr_t)-1:0]);
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      full_q <= '0;
      free_q <= '1;
    end else begin
      for (int b = 0; b < 2; b++) begin
        if (last_word && (wr_bank_q == 1'(b))) full_q[b] <= 1'b1;
        else if (i_take_rd && (i_rd_bank == 1'(b))) full_q[b] <= 1'b0;
        if (take_wr && (wr_bank_q == 1'(b))) free_q[b] <= 1'b0;
        else if (i_release_rd && (i_rd_bank == 1'(b))) free_q[b] <= 1'b1;
      end
    end
  end

  assign o_full    = full_q;
  assign o_rd_hdr  = hdr_q[i_rd_bank];
  assign o_wr_en   = s_hs && (state == W_WRITE);
  assign o_wr_bank = wr_bank_q;
  assign o_wr_addr = AW'(wr_cnt);
  assign o_wr_data = i_s_data;

endmodule

`default_nettype wire

//--- rtl/rotator_pkg.sv
// **********************************************************
// weight rotator shared types
// header fields of a weight block, output sideband flags
// and the per-bank flag vector used by the bank handshake
// **********************************************************
`default_nettype none

package rotator_pkg;

  // word count and pass count field widths
  localparam int LEN_BITS = 8;
  localparam int REP_BITS = 4;

  // header beat taken from the low bits of the first word
  typedef struct packed {
    logic [LEN_BITS-1:0] len_1;
    logic [REP_BITS-1:0] reps_1;
  } hdr_t;

  // sideband carried with every output word
  typedef struct packed {
    logic is_first_word;
    logic is_last_pass;
  } out_user_t;

  // one bit per bank for both full and free
  typedef logic [1:0] bank_flags_t;

endpackage

`default_nettype wire
